// File: credit_link_defs.svh
// ~~~~~~~~~~~~~~~~~~~~
// Sizes of the credit link: flit width, receive FIFO depth,
// credit count width and return lane latency.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef CREDIT_LINK_DEFS_SVH
`define CREDIT_LINK_DEFS_SVH

// Payload bits carried by each flit.
`define LINK_DATA_WIDTH 32

// Receive FIFO entries. The sender starts out with exactly this many credits.
`define LINK_FIFO_DEPTH 16

`define CREDIT_WIDTH 8            // Holds every outstanding plus pending credit without wrap.

`define CREDIT_RETURN_LATENCY 4   // Edges from grant acceptance to the update pulse.

`endif

// File: credit_link_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared types of the credit link: credit count, flit and credit message.
// ~~~~~~~~~~~~~~~~~~~~

`include "credit_link_defs.svh"

package credit_link_pkg;

    // Every credit count in the design uses this width.
    typedef logic [`CREDIT_WIDTH-1:0] credit_t;

    // One flit on the forward path.
    typedef struct packed {
        logic [`LINK_DATA_WIDTH-1:0] data;
        logic                        last;  // Marks the final flit of a packet.
        logic [7:0]                  tag;   // Sequence number stamped by the sender.
    } link_flit_t;

    // One grant travelling back on the return lane.
    typedef struct packed {
        credit_t count;
    } credit_msg_t;

endpackage

// File: credit_capacity_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~
// Credit capacity buffer that merges slot releases into credit grants.
// ~~~~~~~~~~~~~~~~~~~~

`include "credit_link_defs.svh"

module credit_capacity_buffer import credit_link_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  credit_t     release_size,
    input  logic        release_valid,
    output credit_msg_t grant,
    output logic        grant_valid,
    input  logic        grant_ready,
    output credit_t     pending_credits
);

    credit_t     queued;       // Released slots not yet handed to a grant.
    logic        queue_empty;
    credit_msg_t grant_reg;

    credit_t     queued_next;
    logic        queue_empty_next;
    credit_msg_t grant_next;
    logic        grant_valid_next;

    // The steps run in order, so a release on the same edge as a move
    // lands in the freshly cleared queue.
    always_comb begin
        queued_next      = queued;
        queue_empty_next = queue_empty;
        grant_next       = grant_reg;
        grant_valid_next = grant_valid;

        if (grant_ready) begin
            grant_valid_next = 1'b0;
        end

        if (!grant_valid_next && !queue_empty_next) begin
            grant_next.count = queued_next;   // The whole sum goes out as one grant.
            grant_valid_next = 1'b1;
            queued_next      = '0;
            queue_empty_next = 1'b1;
        end

        if (release_valid) begin
            queued_next      = queued_next + release_size;
            queue_empty_next = queue_empty_next && (release_size == '0);
        end
    end

    // At reset the queue holds the whole FIFO depth, so the first grant
    // hands the sender all of its credits.
    always_ff @(posedge clk) begin
        if (reset) begin
            queued      <= credit_t'(`LINK_FIFO_DEPTH);
            queue_empty <= 1'b0;
            grant_valid <= 1'b0;
        end else begin
            queued      <= queued_next;
            queue_empty <= queue_empty_next;
            grant_valid <= grant_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        grant_reg <= grant_next;
    end

    assign grant           = grant_reg;
    assign pending_credits = queued;

    // A grant stalled by a busy return lane must not change or vanish.
    a_grant_hold: assert property (@(posedge clk) disable iff (reset)
        grant_valid && !grant_ready |=> grant_valid && $stable(grant))
        else $error("Credit grant changed while stalled.");

endmodule

// File: credit_sender.sv
// ~~~~~~~~~~~~~~~~~~~~
// Credit link sender with credit counter and tag stamping.
// ~~~~~~~~~~~~~~~~~~~~

`include "credit_link_defs.svh"

module credit_sender import credit_link_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  link_flit_t  in_flit,
    input  logic        in_valid,
    output logic        in_ready,
    output link_flit_t  link_flit,
    output logic        link_valid,
    input  credit_msg_t credit_update,
    input  logic        credit_update_valid
);

    credit_t    credits;      // Free receive FIFO slots known to the sender.
    credit_t    credit_add;
    credit_t    credit_use;
    logic [7:0] tag_seq;
    logic       accept;

    assign in_ready   = (credits != '0);
    assign accept     = in_valid && in_ready;
    assign credit_use = accept ? credit_t'(1) : '0;
    assign credit_add = credit_update_valid ? credit_update.count : '0;

    // A returned grant and a send may land on the same edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            credits    <= '0;
            tag_seq    <= '0;
            link_valid <= 1'b0;
        end else begin
            credits    <= credits + credit_add - credit_use;
            link_valid <= accept;
            if (accept) begin
                tag_seq <= tag_seq + 8'd1;   // Wraps modulo 256.
            end
        end
    end

    // The incoming tag field is replaced by the sender's own sequence.
    always_ff @(posedge clk) begin
        if (accept) begin
            link_flit.data <= in_flit.data;
            link_flit.last <= in_flit.last;
            link_flit.tag  <= tag_seq;
        end
    end

    // The return path must never hand back more slots than the FIFO has.
    // An underflow would wrap to a large value and trip this as well.
    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= credit_t'(`LINK_FIFO_DEPTH))
        else $error("Sender credit count out of range: %0d.", credits);

endmodule

// File: credit_rx_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// Receive FIFO of the credit link with early head and pop releases.
// ~~~~~~~~~~~~~~~~~~~~

`include "credit_link_defs.svh"

module credit_rx_fifo import credit_link_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  link_flit_t link_flit,
    input  logic       link_valid,
    output link_flit_t out_flit,
    output logic       out_valid,
    input  logic       out_ready,
    output credit_t    release_size,
    output logic       release_valid
);

    localparam int DEPTH = `LINK_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    link_flit_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             pop;

    assign out_valid = (fill != '0);
    assign out_flit  = mem[rd_ptr];   // Head entry shows before the pop.
    assign pop       = out_valid && out_ready;

    // Every pop frees exactly one slot.
    assign release_valid = pop;
    assign release_size  = credit_t'(1);

    always_ff @(posedge clk) begin
        if (link_valid) begin
            mem[wr_ptr] <= link_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (link_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({link_valid, pop})
                2'b10:   fill <= fill + CNT_W'(1);
                2'b01:   fill <= fill - CNT_W'(1);
                default: fill <= fill;
            endcase
        end
    end

    // The link has no ready, so the sender's credits alone must prevent overflow.
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        link_valid |-> fill < CNT_W'(DEPTH))
        else $error("Write into a full receive FIFO.");

endmodule

// File: credit_return_channel.sv
// ~~~~~~~~~~~~~~~~~~~~
// Credit return lane carrying one grant at a fixed latency.
// ~~~~~~~~~~~~~~~~~~~~

`include "credit_link_defs.svh"

module credit_return_channel import credit_link_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  credit_msg_t grant,
    input  logic        grant_valid,
    output logic        grant_ready,
    output credit_msg_t credit_update,
    output logic        credit_update_valid
);

    localparam int LATENCY = `CREDIT_RETURN_LATENCY;
    localparam int CNT_W   = $clog2(LATENCY + 1);

    logic             busy;
    logic [CNT_W-1:0] countdown;   // Edges left before the update pulse.
    credit_msg_t      held_msg;
    logic             take;

    // The lane is serial, so a new grant waits until the previous one has landed.
    assign grant_ready = !busy;
    assign take        = grant_valid && grant_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy                <= 1'b0;
            countdown           <= '0;
            credit_update_valid <= 1'b0;
        end else begin
            credit_update_valid <= 1'b0;
            if (take) begin
                busy      <= 1'b1;
                countdown <= CNT_W'(LATENCY - 1);
            end else if (busy) begin
                if (countdown == '0) begin
                    busy                <= 1'b0;
                    credit_update_valid <= 1'b1;   // One-cycle pulse to the sender.
                end else begin
                    countdown <= countdown - CNT_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held_msg <= grant;
        end
    end

    assign credit_update = held_msg;

endmodule

// File: credit_link_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Credit link top: sender, receive FIFO, capacity buffer, return lane.
// ~~~~~~~~~~~~~~~~~~~~

`include "credit_link_defs.svh"

module credit_link_top import credit_link_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  link_flit_t in_flit,
    input  logic       in_valid,
    output logic       in_ready,
    output link_flit_t out_flit,
    output logic       out_valid,
    input  logic       out_ready,
    output credit_t    pending_credits
);

    // Forward link from the sender into the FIFO.
    link_flit_t  link_flit;
    logic        link_valid;

    // Slot releases, merged grants and the credit updates that close the loop.
    credit_t     release_size;
    logic        release_valid;
    credit_msg_t grant;
    logic        grant_valid;
    logic        grant_ready;
    credit_msg_t credit_update;
    logic        credit_update_valid;

    credit_sender u_sender (
        .clk                 (clk),
        .reset               (reset),
        .in_flit             (in_flit),
        .in_valid            (in_valid),
        .in_ready            (in_ready),
        .link_flit           (link_flit),
        .link_valid          (link_valid),
        .credit_update       (credit_update),
        .credit_update_valid (credit_update_valid)
    );

    credit_rx_fifo u_rx_fifo (
        .clk           (clk),
        .reset         (reset),
        .link_flit     (link_flit),
        .link_valid    (link_valid),
        .out_flit      (out_flit),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .release_size  (release_size),
        .release_valid (release_valid)
    );

    credit_capacity_buffer u_capacity (
        .clk             (clk),
        .reset           (reset),
        .release_size    (release_size),
        .release_valid   (release_valid),
        .grant           (grant),
        .grant_valid     (grant_valid),
        .grant_ready     (grant_ready),
        .pending_credits (pending_credits)
    );

    credit_return_channel u_return (
        .clk                 (clk),
        .reset               (reset),
        .grant               (grant),
        .grant_valid         (grant_valid),
        .grant_ready         (grant_ready),
        .credit_update       (credit_update),
        .credit_update_valid (credit_update_valid)
    );

endmodule

// File: credit_link_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the credit link: phase table, scoreboard and checks.
// ~~~~~~~~~~~~~~~~~~~~

`include "credit_link_defs.svh"

module credit_link_tb import credit_link_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH        = `LINK_FIFO_DEPTH;
    localparam int FILL         = 0;     // The output stalls and exactly DEPTH flits go in.
    localparam int DRAIN        = 1;     // Input stays idle while everything is popped.
    localparam int MIX          = 2;
    localparam int NUM_PHASES   = 8;
    localparam int SEND_TIMEOUT = 4000;
    localparam int IDLE_TIMEOUT = 200;
    localparam int STALL_WINDOW = 40;    // Several credit round trips long.

    typedef struct packed {
        int mode;
        int flits;
        int valid_pct;
        int ready_pct;
    } phase_t;

    logic       clk = 1'b0;
    logic       reset;
    link_flit_t in_flit;
    logic       in_valid;
    logic       in_ready;
    link_flit_t out_flit;
    logic       out_valid;
    logic       out_ready;
    credit_t    pending_credits;

    phase_t     phases [NUM_PHASES];
    link_flit_t scoreboard [$];          // Accepted flits in order with their expected tags.
    integer     seed;
    int         sent_count;
    int         popped_count;
    int         phase_sent;
    int         check_count;
    int         error_count;
    logic       offer_pending;
    logic       timed_out;

    credit_link_top UUT (.*);

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0d ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    // True with the given probability in percent.
    function automatic bit roll_percent(input int pct);
        logic [31:0] draw;
        draw = $random(seed);
        return (draw % 32'd100) < 32'(pct);
    endfunction

    function automatic string mode_name(input int mode);
        case (mode)
            FILL:    return "fill";
            DRAIN:   return "drain";
            default: return "mixed";
        endcase
    endfunction

    // One clock cycle. Inputs change on the falling edge and the handshakes
    // that the next rising edge will complete are sampled right after.
    task automatic run_cycle(input logic allow_send, input int valid_pct, input int ready_pct);
        link_flit_t  expect_flit;
        logic [31:0] draw;
        @(negedge clk);
        if (!offer_pending) begin    // An offered flit stays put until it is taken.
            draw         = $random(seed);
            in_valid     = allow_send && roll_percent(valid_pct);
            in_flit.data = $random(seed);
            in_flit.last = draw[0];
            in_flit.tag  = draw[15:8];   // The sender overwrites this field.
        end
        out_ready = roll_percent(ready_pct);
        #1;
        if (in_valid && in_ready) begin
            expect_flit     = in_flit;
            expect_flit.tag = sent_count[7:0];
            scoreboard.push_back(expect_flit);
            sent_count++;
            phase_sent++;
        end
        offer_pending = in_valid && !in_ready;
        if (out_valid && out_ready) begin
            if (scoreboard.size() == 0) begin
                $display("Pop at %0d ns while no accepted flit was outstanding.", $time);
                error_count++;
            end else begin
                expect_flit = scoreboard.pop_front();
                check_value("out_flit.data", 64'(expect_flit.data), 64'(out_flit.data));
                check_value("out_flit.last", 64'(expect_flit.last), 64'(out_flit.last));
                check_value("out_flit.tag", 64'(expect_flit.tag), 64'(out_flit.tag));
            end
            popped_count++;
        end
        // The credits bound the flits between input and output.
        check_value("in_flight_within_depth", 64'(1), 64'(sent_count - popped_count <= DEPTH));
    endtask

    task automatic run_phase(input int idx);
        phase_t p;
        int     cycles;
        int     errors_before;
        p             = phases[idx];
        phase_sent    = 0;
        errors_before = error_count;
        cycles        = 0;
        if (p.mode == DRAIN) begin
            while (scoreboard.size() != 0 && cycles < SEND_TIMEOUT) begin
                run_cycle(1'b0, 0, p.ready_pct);
                cycles++;
            end
            cycles = 0;
            while (pending_credits != '0 && cycles < IDLE_TIMEOUT) begin
                run_cycle(1'b0, 0, p.ready_pct);
                cycles++;
            end
            if (scoreboard.size() != 0 || pending_credits != '0) begin
                $display("Timeout in phase %0d: FIFO or credit queue did not drain.", idx);
                timed_out = 1'b1;
            end
        end else begin
            while (phase_sent < p.flits && cycles < SEND_TIMEOUT) begin
                run_cycle(1'b1, p.valid_pct, p.ready_pct);
                cycles++;
            end
            if (phase_sent < p.flits) begin
                $display("Timeout in phase %0d: only %0d of %0d flits were accepted.",
                         idx, phase_sent, p.flits);
                timed_out = 1'b1;
            end else if (p.mode == FILL) begin
                // Nothing is popped, so no credit can come back.
                repeat (STALL_WINDOW) begin
                    run_cycle(1'b0, 0, 0);
                    check_value("in_ready", 64'(0), 64'(in_ready));
                end
            end
        end
        $display("Phase %0d (%s) done: %0d accepted here, %0d popped so far, %0d new errors",
                 idx, mode_name(p.mode), phase_sent, popped_count, error_count - errors_before);
    endtask

    initial begin
        seed          = 36283;
        reset         = 1'b1;
        in_flit       = '0;
        in_valid      = 1'b0;
        out_ready     = 1'b0;
        sent_count    = 0;
        popped_count  = 0;
        check_count   = 0;
        error_count   = 0;
        offer_pending = 1'b0;
        timed_out     = 1'b0;

        phases[0] = '{FILL, DEPTH, 100, 0};
        phases[1] = '{DRAIN, 0, 0, 100};
        phases[2] = '{FILL, DEPTH, 100, 0};   // Credits must all be back after the drain.
        phases[3] = '{MIX, 200, 70, 40};
        phases[4] = '{MIX, 200, 35, 90};
        phases[5] = '{DRAIN, 0, 0, 100};
        phases[6] = '{FILL, DEPTH, 60, 0};
        phases[7] = '{DRAIN, 0, 0, 100};

        repeat (4) begin
            @(negedge clk);
            check_value("in_ready", 64'(0), 64'(in_ready));
            check_value("out_valid", 64'(0), 64'(out_valid));
        end
        reset = 1'b0;
        @(negedge clk);
        check_value("in_ready", 64'(0), 64'(in_ready));
        check_value("out_valid", 64'(0), 64'(out_valid));
        $display("Reset check done: %0d errors", error_count);

        for (int i = 0; i < NUM_PHASES && !timed_out; i++) begin
            run_phase(i);
        end

        $display("Summary: %0d checks, %0d errors, %0d flits accepted, %0d flits popped",
                 check_count, error_count, sent_count, popped_count);
        if (error_count == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: credit_link_top.f
+incdir+.
credit_link_pkg.sv
credit_capacity_buffer.sv
credit_sender.sv
credit_rx_fifo.sv
credit_return_channel.sv
credit_link_top.sv
credit_link_tb.sv

// File: Makefile
# Verilator build and run of the credit link testbench.

VERILATOR ?= verilator
TOP       ?= credit_link_tb
FILELIST  ?= credit_link_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result; a run without a verdict counts as a failure.
run: compile
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "Simulation reported failures, see $(LOG)"; exit 1; \
	elif ! grep -q "All checks passed" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
